// File: Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = axi_register_slice_tb
RTL_TOP  = axi_register_slice_back_end
FLIST    = sim.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

# lint the design top only
lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

# build and run the testbench, then scan the log
sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)

// File: dv/axi_register_slice_tb.sv
// axi_register_slice_tb: lfsr stimulus, per-channel scoreboards, reference function, compare task
`timescale 1ns/1ns

module axi_register_slice_tb;

  localparam int ar_w        = $bits(axi_be_pkg::axi_ar_t);
  localparam int w_w         = $bits(axi_be_pkg::axi_w_t);
  localparam int r_w         = $bits(axi_be_pkg::axi_r_t);
  localparam int b_w         = $bits(axi_be_pkg::axi_b_t);
  localparam int dw          = w_w;                    // widest payload
  localparam int n_ch        = 5;                      // ar aw w forward, r b back
  localparam int ch_w [n_ch] = '{ar_w, ar_w, w_w, r_w, b_w};
  localparam int items       = 200;                    // random items per channel
  localparam int max_cycles  = items * 8 + 400;        // 8 cycles per item worst case, plus reset

  logic                    ap_clk;
  logic                    reset;
  logic [n_ch-1:0]         src_valid;                  // source side, driven here
  logic [n_ch-1:0]         src_ready;
  logic [dw-1:0]           src_data [n_ch];
  logic [n_ch-1:0]         snk_valid;                  // sink side, from the DUT
  logic [n_ch-1:0]         snk_ready;
  logic [dw-1:0]           snk_data [n_ch];            // zero-extended payloads
  axi_be_pkg::axi_ar_t     s_ar;
  axi_be_pkg::axi_aw_t     s_aw;
  axi_be_pkg::axi_w_t      s_w;
  axi_be_pkg::axi_r_t      m_r;
  axi_be_pkg::axi_b_t      m_b;
  axi_be_pkg::axi_ar_t     m_ar;
  axi_be_pkg::axi_aw_t     m_aw;
  axi_be_pkg::axi_w_t      m_w;
  axi_be_pkg::axi_r_t      s_r;
  axi_be_pkg::axi_b_t      s_b;

  logic [31:0]             lfsr = 32'h93ac_aafa;
  logic [1:0]              src_mode;                   // 0 idle, 1 random, 2 always valid
  logic [1:0]              snk_mode [n_ch];            // 0 stalled, 1 ready, 2 random
  logic [n_ch-1:0]         fired;                      // input transfer at the last rising edge
  logic                    lat_on;                     // latency check armed
  logic [dw-1:0]           expect_q [n_ch][$];
  int                      stamp_q [n_ch][$];          // cycle of each accepted item
  int                      acc_cnt [n_ch] = '{default: 0};
  int                      out_cnt [n_ch] = '{default: 0};
  int                      cycle = 0;
  int                      error_count = 0;
  int                      check_count = 0;

  assign s_ar        = src_data[0][ar_w-1:0];
  assign s_aw        = src_data[1][ar_w-1:0];
  assign s_w         = src_data[2];
  assign m_r         = src_data[3][r_w-1:0];
  assign m_b         = src_data[4][b_w-1:0];
  assign snk_data[0] = {{(dw-ar_w){1'b0}}, m_ar};
  assign snk_data[1] = {{(dw-ar_w){1'b0}}, m_aw};
  assign snk_data[2] = m_w;
  assign snk_data[3] = {{(dw-r_w){1'b0}}, s_r};
  assign snk_data[4] = {{(dw-b_w){1'b0}}, s_b};

  always #50 ap_clk = ~ap_clk;                         // 100 ns period

  axi_register_slice_back_end DUT (
    .ap_clk(ap_clk), .reset(reset),
    .s_axi_araddr(s_ar.addr), .s_axi_arid(s_ar.id), .s_axi_arlen(s_ar.len),
    .s_axi_arsize(s_ar.size), .s_axi_arburst(s_ar.burst), .s_axi_arcache(s_ar.cache),
    .s_axi_arprot(s_ar.prot), .s_axi_arqos(s_ar.qos), .s_axi_arregion(s_ar.region),
    .s_axi_arlock(s_ar.lock), .s_axi_arvalid(src_valid[0]), .s_axi_arready(src_ready[0]),
    .s_axi_awaddr(s_aw.addr), .s_axi_awid(s_aw.id), .s_axi_awlen(s_aw.len),
    .s_axi_awsize(s_aw.size), .s_axi_awburst(s_aw.burst), .s_axi_awcache(s_aw.cache),
    .s_axi_awprot(s_aw.prot), .s_axi_awqos(s_aw.qos), .s_axi_awregion(s_aw.region),
    .s_axi_awlock(s_aw.lock), .s_axi_awvalid(src_valid[1]), .s_axi_awready(src_ready[1]),
    .s_axi_wdata(s_w.data), .s_axi_wstrb(s_w.strb), .s_axi_wlast(s_w.last),
    .s_axi_wvalid(src_valid[2]), .s_axi_wready(src_ready[2]),
    .s_axi_rdata(s_r.data), .s_axi_rid(s_r.id), .s_axi_rresp(s_r.resp), .s_axi_rlast(s_r.last),
    .s_axi_rvalid(snk_valid[3]), .s_axi_rready(snk_ready[3]),
    .s_axi_bid(s_b.id), .s_axi_bresp(s_b.resp),
    .s_axi_bvalid(snk_valid[4]), .s_axi_bready(snk_ready[4]),
    .m_axi_araddr(m_ar.addr), .m_axi_arid(m_ar.id), .m_axi_arlen(m_ar.len),
    .m_axi_arsize(m_ar.size), .m_axi_arburst(m_ar.burst), .m_axi_arcache(m_ar.cache),
    .m_axi_arprot(m_ar.prot), .m_axi_arqos(m_ar.qos), .m_axi_arregion(m_ar.region),
    .m_axi_arlock(m_ar.lock), .m_axi_arvalid(snk_valid[0]), .m_axi_arready(snk_ready[0]),
    .m_axi_awaddr(m_aw.addr), .m_axi_awid(m_aw.id), .m_axi_awlen(m_aw.len),
    .m_axi_awsize(m_aw.size), .m_axi_awburst(m_aw.burst), .m_axi_awcache(m_aw.cache),
    .m_axi_awprot(m_aw.prot), .m_axi_awqos(m_aw.qos), .m_axi_awregion(m_aw.region),
    .m_axi_awlock(m_aw.lock), .m_axi_awvalid(snk_valid[1]), .m_axi_awready(snk_ready[1]),
    .m_axi_wdata(m_w.data), .m_axi_wstrb(m_w.strb), .m_axi_wlast(m_w.last),
    .m_axi_wvalid(snk_valid[2]), .m_axi_wready(snk_ready[2]),
    .m_axi_rdata(m_r.data), .m_axi_rid(m_r.id), .m_axi_rresp(m_r.resp), .m_axi_rlast(m_r.last),
    .m_axi_rvalid(src_valid[3]), .m_axi_rready(src_ready[3]),
    .m_axi_bid(m_b.id), .m_axi_bresp(m_b.resp),
    .m_axi_bvalid(src_valid[4]), .m_axi_bready(src_ready[4])
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic next_bit();                 // galois step, one bit out
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 32'ha300_0000;                     // taps 32 30 26 25
    end
    return lsb;
  endfunction

  function automatic logic [dw-1:0] random_bits(input int n);
    logic [dw-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = next_bit();
    end
    return v;
  endfunction

  // the far side sees the channel's payload bits unchanged, nothing above them
  function automatic logic [dw-1:0] expected_beat(input int c, input logic [dw-1:0] sent);
    logic [dw-1:0] mask;
    mask = '1;
    if (ch_w[c] < dw) begin
      mask = (dw'(1) << ch_w[c]) - dw'(1);
    end
    return sent & mask;
  endfunction

  function automatic string port_name(input int c, input logic out_side);
    string pre;
    string ch;
    pre = "s_axi_";
    if ((c < 3) == out_side) begin
      pre = "m_axi_";                                  // forward outputs and return inputs
    end
    case (c)
      0: ch = "ar";
      1: ch = "aw";
      2: ch = "w";
      3: ch = "r";
      default: ch = "b";
    endcase
    return {pre, ch};
  endfunction

  task automatic check_value(input string name, input logic [dw-1:0] got,
                             input logic [dw-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic set_modes(input logic [1:0] src, input logic [1:0] snk, input logic [1:0] w_snk);
    @(posedge ap_clk);                                 // driver picks them up at the next fall
    src_mode = src;
    for (int c = 0; c < n_ch; c++) begin
      snk_mode[c] = snk;
    end
    snk_mode[2] = w_snk;
  endtask

  task automatic drain();
    set_modes(2'd0, 2'd1, 2'd1);
    while (src_valid != '0) begin
      @(negedge ap_clk);
    end
    repeat (3) @(negedge ap_clk);                      // empty slices flush in two
    for (int c = 0; c < n_ch; c++) begin
      if (expect_q[c].size() != 0) begin
        report_failure($sformatf("%s still owes %0d items", port_name(c, 1'b1),
                                 expect_q[c].size()));
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // processes
  // --------------------------------------------------------------------------
  always @(negedge ap_clk) begin : watchdog
    if (cycle > max_cycles) begin
      report_failure($sformatf("run did not finish within %0d cycles", max_cycles));
      finish_run();
    end
  end

  always @(negedge ap_clk) begin : driver
    logic go;
    for (int c = 0; c < n_ch; c++) begin
      if (!src_valid[c] || fired[c]) begin            // held until taken
        case (src_mode)
          2'd1: go = next_bit() | next_bit();          // about 3/4
          2'd2: go = 1'b1;
          default: go = 1'b0;
        endcase
        src_valid[c] = go;
        if (go) begin
          src_data[c] = random_bits(ch_w[c]);
        end
      end
      case (snk_mode[c])
        2'd1: snk_ready[c] = 1'b1;
        2'd2: snk_ready[c] = next_bit();               // about 1/2
        default: snk_ready[c] = 1'b0;
      endcase
    end
  end

  always @(posedge ap_clk) begin : scoreboard
    int lat;
    cycle++;
    for (int c = 0; c < n_ch; c++) begin
      fired[c] = src_valid[c] & src_ready[c];
      if (snk_valid[c] && snk_ready[c]) begin
        out_cnt[c]++;
        if (expect_q[c].size() == 0) begin
          report_failure($sformatf("%s delivered an item that was never sent", port_name(c, 1'b1)));
        end else begin
          check_value({port_name(c, 1'b1), " payload"}, snk_data[c], expect_q[c].pop_front());
          lat = cycle - stamp_q[c].pop_front();
          if (lat_on) begin
            check_value({port_name(c, 1'b1), " latency"}, dw'(lat), dw'(1));
          end
        end
      end
      if (fired[c]) begin                              // after the pop, queue stays in order
        acc_cnt[c]++;
        expect_q[c].push_back(expected_beat(c, src_data[c]));
        stamp_q[c].push_back(cycle);
      end
    end
  end

  initial begin
    int  acc0 [n_ch];
    int  out0 [n_ch];
    int  n;
    logic done;
    ap_clk    = 1'b0;
    reset     = 1'b1;
    src_mode  = 2'd0;
    src_valid = '0;
    snk_ready = '0;
    lat_on    = 1'b0;
    for (int c = 0; c < n_ch; c++) begin
      src_data[c] = '0;
      snk_mode[c] = 2'd0;
    end
    repeat (2) @(negedge ap_clk);                      // slice reset lands on the second edge
    repeat (3) begin
      @(negedge ap_clk);
      check_value("valids and readies in reset", dw'({snk_valid, src_ready}), '0);
    end
    reset = 1'b0;                                      // after five rising edges
    n = 0;
    while (src_ready != '1) begin
      @(negedge ap_clk);
      n++;
    end
    if (n > 2) begin
      report_failure($sformatf("input readies rose %0d cycles after reset", n));
    end
    check_value("output valids after reset", dw'(snk_valid), '0);

    // ------------------------------------------------------------------------
    // latency, back to back through empty slices
    // ------------------------------------------------------------------------
    acc0   = acc_cnt;
    lat_on = 1'b1;
    set_modes(2'd2, 2'd1, 2'd1);
    repeat (20) @(negedge ap_clk);
    for (int c = 0; c < n_ch; c++) begin
      if (acc_cnt[c] - acc0[c] < 18) begin
        report_failure($sformatf("%s took only %0d items back to back", port_name(c, 1'b0),
                                 acc_cnt[c] - acc0[c]));
      end
    end
    drain();
    lat_on = 1'b0;

    // back-pressure, two items then ready low
    acc0 = acc_cnt;
    set_modes(2'd2, 2'd0, 2'd0);
    repeat (8) @(negedge ap_clk);
    for (int c = 0; c < n_ch; c++) begin
      check_value({port_name(c, 1'b0), " accepted under stall"}, dw'(acc_cnt[c] - acc0[c]), dw'(2));
    end
    check_value("input readies under stall", dw'(src_ready), '0);
    check_value("output valids under stall", dw'(snk_valid), dw'(5'h1f));
    drain();

    // ------------------------------------------------------------------------
    // independence, w output stalled
    // ------------------------------------------------------------------------
    acc0 = acc_cnt;
    out0 = out_cnt;
    set_modes(2'd2, 2'd1, 2'd0);
    repeat (16) @(negedge ap_clk);
    if (out_cnt[0] - out0[0] < 12 || out_cnt[3] - out0[3] < 12) begin
      report_failure("ar or r traffic stalled behind the w stall");
    end
    check_value("s_axi_w accepted under stall", dw'(acc_cnt[2] - acc0[2]), dw'(2));
    drain();

    // random traffic on all five channels
    out0 = out_cnt;
    set_modes(2'd1, 2'd2, 2'd2);
    done = 1'b0;
    while (!done) begin
      @(negedge ap_clk);
      done = 1'b1;
      for (int c = 0; c < n_ch; c++) begin
        if (out_cnt[c] - out0[c] < items) begin
          done = 1'b0;
        end
      end
    end
    drain();
    finish_run();
  end

endmodule : axi_register_slice_tb

// File: hdl/axi_be_if.sv
// axi_be_if: five axi4 channel groups (valid, ready, payload) with mst and slv modports
`timescale 1ns/1ns

interface axi_be_if;

  // --------------------------------------------------------------------------
  // forward channels
  // --------------------------------------------------------------------------
  logic                ar_valid;
  logic                ar_ready;
  axi_be_pkg::axi_ar_t ar_payload;   // read address

  logic                aw_valid;
  logic                aw_ready;
  axi_be_pkg::axi_aw_t aw_payload;   // write address

  logic                w_valid;
  logic                w_ready;
  axi_be_pkg::axi_w_t  w_payload;    // write data beat

  // --------------------------------------------------------------------------
  // return channels
  // --------------------------------------------------------------------------
  logic                r_valid;
  logic                r_ready;
  axi_be_pkg::axi_r_t  r_payload;    // read data beat

  logic                b_valid;
  logic                b_ready;
  axi_be_pkg::axi_b_t  b_payload;    // write response

  // requester side, issues ar/aw/w and sinks r/b
  modport mst (
    output ar_valid, ar_payload,
    input  ar_ready,
    output aw_valid, aw_payload,
    input  aw_ready,
    output w_valid, w_payload,
    input  w_ready,
    input  r_valid, r_payload,
    output r_ready,
    input  b_valid, b_payload,
    output b_ready
  );

  // responder side, the mirror of mst
  modport slv (
    input  ar_valid, ar_payload,
    output ar_ready,
    input  aw_valid, aw_payload,
    output aw_ready,
    input  w_valid, w_payload,
    output w_ready,
    output r_valid, r_payload,
    input  r_ready,
    output b_valid, b_payload,
    input  b_ready
  );

endinterface : axi_be_if

// File: hdl/axi_be_pkg.sv
// axi_be_pkg: axi4 back-end widths, field widths and per-channel payload structs
package axi_be_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int axi_addr_w   = 64;            // byte address
  localparam int axi_data_w   = 512;           // one memory beat
  localparam int axi_strb_w   = axi_data_w/8;  // one strobe per byte
  localparam int axi_id_w     = 1;             // single id, no reordering here
  localparam int axi_len_w    = 8;             // axi4 burst length
  localparam int axi_size_w   = 3;
  localparam int axi_burst_w  = 2;
  localparam int axi_cache_w  = 4;
  localparam int axi_prot_w   = 3;
  localparam int axi_qos_w    = 4;
  localparam int axi_region_w = 4;
  localparam int axi_resp_w   = 2;

  // --------------------------------------------------------------------------
  // channel payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [axi_addr_w-1:0]   addr;
    logic [axi_id_w-1:0]     id;
    logic [axi_len_w-1:0]    len;
    logic [axi_size_w-1:0]   size;   // bytes per beat, log2
    logic [axi_burst_w-1:0]  burst;
    logic [axi_cache_w-1:0]  cache;
    logic [axi_prot_w-1:0]   prot;
    logic [axi_qos_w-1:0]    qos;
    logic [axi_region_w-1:0] region;
    logic                    lock;   // one bit, axi4 has no locked bursts
  } axi_ar_t;                        // 94 bits

  typedef axi_ar_t axi_aw_t;         // write address carries the same fields

  typedef struct packed {
    logic [axi_data_w-1:0] data;
    logic [axi_strb_w-1:0] strb;
    logic                  last;
  } axi_w_t;                         // 577 bits

  typedef struct packed {
    logic [axi_data_w-1:0] data;
    logic [axi_id_w-1:0]   id;
    logic [axi_resp_w-1:0] resp;
    logic                  last;
  } axi_r_t;                         // 516 bits

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_resp_w-1:0] resp;
  } axi_b_t;                         // 3 bits

endpackage : axi_be_pkg

// File: hdl/axi_channel_slice.sv
// axi_channel_slice: two-entry skid register slice for one valid/ready channel
`timescale 1ns/1ns

module axi_channel_slice #(
  parameter type payload_t = logic
) (
  input  logic     ap_clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  // --------------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------------
  logic     out_valid_q;     // output register occupied
  logic     skid_valid_q;    // skid register occupied
  logic     in_ready_q;      // registered skid-empty
  payload_t out_payload_q;
  payload_t skid_payload_q;

  logic     in_fire;         // input transfer this cycle
  logic     out_open;        // output empty or draining
  logic     load_from_skid;
  logic     load_from_in;
  logic     load_skid;
  logic     out_valid_d;
  logic     skid_valid_d;

  assign in_fire        = in_valid & in_ready_q;
  assign out_open       = ~out_valid_q | out_ready;
  assign load_from_skid = out_open & skid_valid_q;               // oldest item first
  assign load_from_in   = out_open & ~skid_valid_q & in_fire;    // straight to output
  assign load_skid      = ~out_open & in_fire;                   // output stalled, park it

  // in_ready_q tracks ~skid_valid_q, so a full skid never sees in_fire
  always_comb begin
    out_valid_d  = out_valid_q;
    skid_valid_d = skid_valid_q;
    if (out_open) begin
      out_valid_d  = skid_valid_q | in_fire;
      skid_valid_d = 1'b0;                                       // skid drains into output
    end else if (in_fire) begin
      skid_valid_d = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // control registers
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready_q   <= 1'b0;                                      // closed while in reset
    end else begin
      out_valid_q  <= out_valid_d;
      skid_valid_q <= skid_valid_d;
      in_ready_q   <= ~skid_valid_d;                             // drops the cycle after skid fills
    end
  end

  // --------------------------------------------------------------------------
  // payload registers
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (load_from_skid) begin
      out_payload_q <= skid_payload_q;
    end else if (load_from_in) begin
      out_payload_q <= in_payload;
    end
    if (load_skid) begin
      skid_payload_q <= in_payload;
    end
  end

  assign in_ready    = in_ready_q;
  assign out_valid   = out_valid_q;
  assign out_payload = out_payload_q;

endmodule : axi_channel_slice

// File: hdl/axi_register_slice_back_end.sv
// axi_register_slice_back_end: flat axi4 slave and master ports around the slice core
`timescale 1ns/1ns

module axi_register_slice_back_end (
  input  logic                                ap_clk,
  input  logic                                reset,
  // slave side, from the engine
  input  logic [axi_be_pkg::axi_addr_w-1:0]   s_axi_araddr,
  input  logic [axi_be_pkg::axi_id_w-1:0]     s_axi_arid,
  input  logic [axi_be_pkg::axi_len_w-1:0]    s_axi_arlen,
  input  logic [axi_be_pkg::axi_size_w-1:0]   s_axi_arsize,
  input  logic [axi_be_pkg::axi_burst_w-1:0]  s_axi_arburst,
  input  logic [axi_be_pkg::axi_cache_w-1:0]  s_axi_arcache,
  input  logic [axi_be_pkg::axi_prot_w-1:0]   s_axi_arprot,
  input  logic [axi_be_pkg::axi_qos_w-1:0]    s_axi_arqos,
  input  logic [axi_be_pkg::axi_region_w-1:0] s_axi_arregion,
  input  logic                                s_axi_arlock,
  input  logic                                s_axi_arvalid,
  output logic                                s_axi_arready,
  input  logic [axi_be_pkg::axi_addr_w-1:0]   s_axi_awaddr,
  input  logic [axi_be_pkg::axi_id_w-1:0]     s_axi_awid,
  input  logic [axi_be_pkg::axi_len_w-1:0]    s_axi_awlen,
  input  logic [axi_be_pkg::axi_size_w-1:0]   s_axi_awsize,
  input  logic [axi_be_pkg::axi_burst_w-1:0]  s_axi_awburst,
  input  logic [axi_be_pkg::axi_cache_w-1:0]  s_axi_awcache,
  input  logic [axi_be_pkg::axi_prot_w-1:0]   s_axi_awprot,
  input  logic [axi_be_pkg::axi_qos_w-1:0]    s_axi_awqos,
  input  logic [axi_be_pkg::axi_region_w-1:0] s_axi_awregion,
  input  logic                                s_axi_awlock,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  input  logic [axi_be_pkg::axi_data_w-1:0]   s_axi_wdata,
  input  logic [axi_be_pkg::axi_strb_w-1:0]   s_axi_wstrb,
  input  logic                                s_axi_wlast,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  output logic [axi_be_pkg::axi_data_w-1:0]   s_axi_rdata,
  output logic [axi_be_pkg::axi_id_w-1:0]     s_axi_rid,
  output logic [axi_be_pkg::axi_resp_w-1:0]   s_axi_rresp,
  output logic                                s_axi_rlast,
  output logic                                s_axi_rvalid,
  input  logic                                s_axi_rready,
  output logic [axi_be_pkg::axi_id_w-1:0]     s_axi_bid,
  output logic [axi_be_pkg::axi_resp_w-1:0]   s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  // master side, to the memory controller
  output logic [axi_be_pkg::axi_addr_w-1:0]   m_axi_araddr,
  output logic [axi_be_pkg::axi_id_w-1:0]     m_axi_arid,
  output logic [axi_be_pkg::axi_len_w-1:0]    m_axi_arlen,
  output logic [axi_be_pkg::axi_size_w-1:0]   m_axi_arsize,
  output logic [axi_be_pkg::axi_burst_w-1:0]  m_axi_arburst,
  output logic [axi_be_pkg::axi_cache_w-1:0]  m_axi_arcache,
  output logic [axi_be_pkg::axi_prot_w-1:0]   m_axi_arprot,
  output logic [axi_be_pkg::axi_qos_w-1:0]    m_axi_arqos,
  output logic [axi_be_pkg::axi_region_w-1:0] m_axi_arregion,
  output logic                                m_axi_arlock,
  output logic                                m_axi_arvalid,
  input  logic                                m_axi_arready,
  output logic [axi_be_pkg::axi_addr_w-1:0]   m_axi_awaddr,
  output logic [axi_be_pkg::axi_id_w-1:0]     m_axi_awid,
  output logic [axi_be_pkg::axi_len_w-1:0]    m_axi_awlen,
  output logic [axi_be_pkg::axi_size_w-1:0]   m_axi_awsize,
  output logic [axi_be_pkg::axi_burst_w-1:0]  m_axi_awburst,
  output logic [axi_be_pkg::axi_cache_w-1:0]  m_axi_awcache,
  output logic [axi_be_pkg::axi_prot_w-1:0]   m_axi_awprot,
  output logic [axi_be_pkg::axi_qos_w-1:0]    m_axi_awqos,
  output logic [axi_be_pkg::axi_region_w-1:0] m_axi_awregion,
  output logic                                m_axi_awlock,
  output logic                                m_axi_awvalid,
  input  logic                                m_axi_awready,
  output logic [axi_be_pkg::axi_data_w-1:0]   m_axi_wdata,
  output logic [axi_be_pkg::axi_strb_w-1:0]   m_axi_wstrb,
  output logic                                m_axi_wlast,
  output logic                                m_axi_wvalid,
  input  logic                                m_axi_wready,
  input  logic [axi_be_pkg::axi_data_w-1:0]   m_axi_rdata,
  input  logic [axi_be_pkg::axi_id_w-1:0]     m_axi_rid,
  input  logic [axi_be_pkg::axi_resp_w-1:0]   m_axi_rresp,
  input  logic                                m_axi_rlast,
  input  logic                                m_axi_rvalid,
  output logic                                m_axi_rready,
  input  logic [axi_be_pkg::axi_id_w-1:0]     m_axi_bid,
  input  logic [axi_be_pkg::axi_resp_w-1:0]   m_axi_bresp,
  input  logic                                m_axi_bvalid,
  output logic                                m_axi_bready
);

  axi_be_if upstream ();       // engine side bundle
  axi_be_if downstream ();     // memory side bundle

  // --------------------------------------------------------------------------
  // slave side, flat ports into upstream
  // --------------------------------------------------------------------------
  assign upstream.ar_valid   = s_axi_arvalid;
  assign upstream.ar_payload = '{addr: s_axi_araddr, id: s_axi_arid, len: s_axi_arlen,
                                 size: s_axi_arsize, burst: s_axi_arburst,
                                 cache: s_axi_arcache, prot: s_axi_arprot, qos: s_axi_arqos,
                                 region: s_axi_arregion, lock: s_axi_arlock};
  assign s_axi_arready       = upstream.ar_ready;
  assign upstream.aw_valid   = s_axi_awvalid;
  assign upstream.aw_payload = '{addr: s_axi_awaddr, id: s_axi_awid, len: s_axi_awlen,
                                 size: s_axi_awsize, burst: s_axi_awburst,
                                 cache: s_axi_awcache, prot: s_axi_awprot, qos: s_axi_awqos,
                                 region: s_axi_awregion, lock: s_axi_awlock};
  assign s_axi_awready       = upstream.aw_ready;
  assign upstream.w_valid    = s_axi_wvalid;
  assign upstream.w_payload  = '{data: s_axi_wdata, strb: s_axi_wstrb, last: s_axi_wlast};
  assign s_axi_wready        = upstream.w_ready;
  assign upstream.r_ready    = s_axi_rready;
  assign s_axi_rvalid        = upstream.r_valid;
  assign {s_axi_rdata, s_axi_rid, s_axi_rresp, s_axi_rlast} = upstream.r_payload;
  assign upstream.b_ready    = s_axi_bready;
  assign s_axi_bvalid        = upstream.b_valid;
  assign {s_axi_bid, s_axi_bresp} = upstream.b_payload;  // field order as in axi_b_t

  // --------------------------------------------------------------------------
  // master side, downstream out to flat ports
  // --------------------------------------------------------------------------
  assign m_axi_arvalid         = downstream.ar_valid;
  assign {m_axi_araddr, m_axi_arid, m_axi_arlen, m_axi_arsize, m_axi_arburst,
          m_axi_arcache, m_axi_arprot, m_axi_arqos, m_axi_arregion,
          m_axi_arlock}        = downstream.ar_payload;   // struct field order
  assign downstream.ar_ready   = m_axi_arready;
  assign m_axi_awvalid         = downstream.aw_valid;
  assign {m_axi_awaddr, m_axi_awid, m_axi_awlen, m_axi_awsize, m_axi_awburst,
          m_axi_awcache, m_axi_awprot, m_axi_awqos, m_axi_awregion,
          m_axi_awlock}        = downstream.aw_payload;
  assign downstream.aw_ready   = m_axi_awready;
  assign m_axi_wvalid          = downstream.w_valid;
  assign {m_axi_wdata, m_axi_wstrb, m_axi_wlast} = downstream.w_payload;
  assign downstream.w_ready    = m_axi_wready;
  assign downstream.r_valid    = m_axi_rvalid;
  assign downstream.r_payload  = '{data: m_axi_rdata, id: m_axi_rid, resp: m_axi_rresp,
                                   last: m_axi_rlast};
  assign m_axi_rready          = downstream.r_ready;
  assign downstream.b_valid    = m_axi_bvalid;
  assign downstream.b_payload  = '{id: m_axi_bid, resp: m_axi_bresp};
  assign m_axi_bready          = downstream.b_ready;

  // --------------------------------------------------------------------------
  // slice core
  // --------------------------------------------------------------------------
  axi_register_slice_be slice_core (
    .ap_clk     (ap_clk),
    .reset      (reset),
    .upstream   (upstream.slv),
    .downstream (downstream.mst)
  );

endmodule : axi_register_slice_back_end

// File: hdl/axi_register_slice_be.sv
// axi_register_slice_be: registered reset and one skid slice per axi4 channel
`timescale 1ns/1ns

module axi_register_slice_be (
  input  logic   ap_clk,
  input  logic   reset,
  axi_be_if.slv  upstream,     // engine side
  axi_be_if.mst  downstream    // memory controller side
);

  logic reset_slice;           // local copy, cuts the reset fan-out path

  always_ff @(posedge ap_clk) begin
    reset_slice <= reset;
  end

  // --------------------------------------------------------------------------
  // forward channels, upstream to downstream
  // --------------------------------------------------------------------------
  axi_channel_slice #(.payload_t(axi_be_pkg::axi_ar_t)) ar_slice (
    .ap_clk      (ap_clk),
    .reset       (reset_slice),
    .in_valid    (upstream.ar_valid),
    .in_ready    (upstream.ar_ready),
    .in_payload  (upstream.ar_payload),
    .out_valid   (downstream.ar_valid),
    .out_ready   (downstream.ar_ready),
    .out_payload (downstream.ar_payload)
  );

  axi_channel_slice #(.payload_t(axi_be_pkg::axi_aw_t)) aw_slice (
    .ap_clk      (ap_clk),
    .reset       (reset_slice),
    .in_valid    (upstream.aw_valid),
    .in_ready    (upstream.aw_ready),
    .in_payload  (upstream.aw_payload),
    .out_valid   (downstream.aw_valid),
    .out_ready   (downstream.aw_ready),
    .out_payload (downstream.aw_payload)
  );

  axi_channel_slice #(.payload_t(axi_be_pkg::axi_w_t)) w_slice (
    .ap_clk      (ap_clk),
    .reset       (reset_slice),
    .in_valid    (upstream.w_valid),
    .in_ready    (upstream.w_ready),
    .in_payload  (upstream.w_payload),
    .out_valid   (downstream.w_valid),
    .out_ready   (downstream.w_ready),
    .out_payload (downstream.w_payload)
  );

  // --------------------------------------------------------------------------
  // return channels, downstream to upstream
  // --------------------------------------------------------------------------
  axi_channel_slice #(.payload_t(axi_be_pkg::axi_r_t)) r_slice (
    .ap_clk      (ap_clk),
    .reset       (reset_slice),
    .in_valid    (downstream.r_valid),
    .in_ready    (downstream.r_ready),
    .in_payload  (downstream.r_payload),
    .out_valid   (upstream.r_valid),
    .out_ready   (upstream.r_ready),
    .out_payload (upstream.r_payload)
  );

  axi_channel_slice #(.payload_t(axi_be_pkg::axi_b_t)) b_slice (
    .ap_clk      (ap_clk),
    .reset       (reset_slice),
    .in_valid    (downstream.b_valid),
    .in_ready    (downstream.b_ready),
    .in_payload  (downstream.b_payload),
    .out_valid   (upstream.b_valid),
    .out_ready   (upstream.b_ready),
    .out_payload (upstream.b_payload)
  );

endmodule : axi_register_slice_be

// File: sim.f
hdl/axi_be_pkg.sv
hdl/axi_be_if.sv
hdl/axi_channel_slice.sv
hdl/axi_register_slice_be.sv
hdl/axi_register_slice_back_end.sv
dv/axi_register_slice_tb.sv
